//--- build.f
src/lpif_link_pkg.sv
src/lpif_phy_pkg.sv
src/lpif_sync_if.sv
src/ll_auto_sync.sv
src/lpif_user_pack.sv
src/lpif_phy_concat.sv
src/lpif_slave_top.sv
tests/lpif_slave_assertions.sv
tests/tb_lpif_slave.sv

//--- Bender.yml
package:
  name: lpif_slave

sources:
  # Packages first, then the bundle interface
  - src/lpif_link_pkg.sv
  - src/lpif_phy_pkg.sv
  - src/lpif_sync_if.sv
  # Design blocks, top level last
  - src/ll_auto_sync.sv
  - src/lpif_user_pack.sv
  - src/lpif_phy_concat.sv
  - src/lpif_slave_top.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - tests/lpif_slave_assertions.sv
      - tests/tb_lpif_slave.sv

//--- tests/tb_lpif_slave.sv
//////////////////////////////////////////////////
// LPIF slave link testbench
// Random user and lane traffic over online episodes
// Cycle model of delays, strobe, packing and lanes
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_lpif_slave;

  localparam int n_episodes   = 8;
  localparam int off_cycles   = 4;
  localparam int on_cycles    = 40;
  localparam int drop_cycles  = 3;
  localparam int total_cycles = 3 + n_episodes * (off_cycles + on_cycles + drop_cycles);
  localparam int watchdog_ns  = (total_cycles + 100) * 4;

  logic                                      clk_wr;
  logic                                      rst_n;
  logic                                      tx_online;
  logic                                      rx_online;
  logic [lpif_phy_pkg::lane_width-1:0]       tx_phy0;
  logic [lpif_phy_pkg::lane_width-1:0]       tx_phy1;
  logic [lpif_phy_pkg::lane_width-1:0]       rx_phy0;
  logic [lpif_phy_pkg::lane_width-1:0]       rx_phy1;
  logic [lpif_link_pkg::state_width-1:0]     dstrm_state;
  logic [lpif_link_pkg::protid_width-1:0]    dstrm_protid;
  logic [lpif_link_pkg::data_width-1:0]      dstrm_data;
  logic [lpif_link_pkg::dvalid_width-1:0]    dstrm_dvalid;
  logic [lpif_link_pkg::crc_width-1:0]       dstrm_crc;
  logic [lpif_link_pkg::crc_valid_width-1:0] dstrm_crc_valid;
  logic [lpif_link_pkg::valid_width-1:0]     dstrm_valid;
  logic [lpif_link_pkg::state_width-1:0]     ustrm_state;
  logic [lpif_link_pkg::protid_width-1:0]    ustrm_protid;
  logic [lpif_link_pkg::data_width-1:0]      ustrm_data;
  logic [lpif_link_pkg::dvalid_width-1:0]    ustrm_dvalid;
  logic [lpif_link_pkg::crc_width-1:0]       ustrm_crc;
  logic [lpif_link_pkg::crc_valid_width-1:0] ustrm_crc_valid;
  logic [lpif_link_pkg::valid_width-1:0]     ustrm_valid;
  logic [31:0]                               rx_downstream_debug_status;
  logic [31:0]                               tx_upstream_debug_status;
  logic                                      m_gen2_mode;
  logic [lpif_phy_pkg::marker_width-1:0]     tx_mrk_userbit;
  logic                                      tx_stb_userbit;
  logic [lpif_phy_pkg::delay_width-1:0]      delay_x_value;
  logic [lpif_phy_pkg::delay_width-1:0]      delay_y_value;
  logic [lpif_phy_pkg::delay_width-1:0]      delay_z_value;

  // Model state
  int   tx_hi;
  int   rx_hi;
  logic tx_flag;
  logic rx_flag;
  int   stb_phase;
  int   errors;
  int   checks;

  lpif_slave_top UUT (.*);

  initial begin
    clk_wr = 1'b0;
    forever #2 clk_wr = ~clk_wr;
  end

  // Watchdog sized from the total cycle count
  initial begin
    #(watchdog_ns);
    $display("Timeout: run did not finish within %0d ns", watchdog_ns);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic compare(input string what, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic int strobe_period(input logic [lpif_phy_pkg::delay_width-1:0] z);
    return (z == '0) ? 1 : int'(z);
  endfunction

  // Lane bits from the top are marker, gen2 strobe, spare zeros, gen1 strobe and half flit
  function automatic logic [lpif_phy_pkg::lane_width-1:0] expected_lane(
    input logic [lpif_phy_pkg::half_width-1:0] half,
    input logic                                mrk,
    input logic                                stb,
    input logic                                gen2
  );
    return {mrk, gen2 & stb, 35'b0, ~gen2 & stb, half};
  endfunction

  task automatic drive_random();
    ustrm_data      = {$urandom, $urandom};
    ustrm_state     = 8'($urandom);
    ustrm_protid    = 4'($urandom);
    ustrm_dvalid    = 2'($urandom);
    ustrm_crc       = 2'($urandom);
    ustrm_crc_valid = 2'($urandom);
    ustrm_valid     = 2'($urandom);
    rx_phy0         = {16'($urandom), $urandom, $urandom};
    rx_phy1         = {16'($urandom), $urandom, $urandom};
    // User sync bits have no effect while offline
    tx_mrk_userbit  = 2'($urandom);
    tx_stb_userbit  = 1'($urandom);
  endtask

  task automatic run_cycle();
    logic [lpif_link_pkg::flit_width-1:0] flit;
    logic [lpif_link_pkg::flit_width-1:0] exp_rx;
    logic [lpif_phy_pkg::lane_width-1:0]  exp_lane0;
    logic [lpif_phy_pkg::lane_width-1:0]  exp_lane1;
    logic [31:0]                          exp_status;
    logic                                 tx_new;
    @(posedge clk_wr);
    // Flit layout from LSB is data, state, protid, dvalid, crc, crc_valid and valid
    flit = {ustrm_valid, ustrm_crc_valid, ustrm_crc, ustrm_dvalid,
            ustrm_protid, ustrm_state, ustrm_data};
    exp_lane0 = '0;
    exp_lane1 = '0;
    if (tx_flag) begin
      exp_lane0 = expected_lane(flit[41:0], lpif_phy_pkg::auto_marker[0],
                                stb_phase == 0, m_gen2_mode);
      exp_lane1 = expected_lane(flit[83:42], lpif_phy_pkg::auto_marker[1],
                                stb_phase == 0, m_gen2_mode);
    end
    // Lane bits 79..42 never reach the user side
    exp_rx = rx_flag ? {rx_phy1[41:0], rx_phy0[41:0]} : '0;
    // Flag rises delay+1 edges after the first high sample
    tx_hi  = tx_online ? tx_hi + 1 : 0;
    rx_hi  = rx_online ? rx_hi + 1 : 0;
    tx_new = (tx_hi >= int'(delay_x_value) + 2);
    if (tx_new && tx_flag) begin
      stb_phase = (stb_phase + 1 >= strobe_period(delay_z_value)) ? 0 : stb_phase + 1;
    end else begin
      stb_phase = 0;
    end
    tx_flag = tx_new;
    rx_flag = (rx_hi >= int'(delay_y_value) + 2);
    exp_status     = '0;
    exp_status[19] = tx_flag;
    exp_status[18] = rx_flag;
    #1;
    compare("tx_phy0", tx_phy0, exp_lane0);
    compare("tx_phy1", tx_phy1, exp_lane1);
    compare("dstrm fields", {dstrm_valid, dstrm_crc_valid, dstrm_crc, dstrm_dvalid,
                             dstrm_protid, dstrm_state, dstrm_data}, exp_rx);
    compare("debug status", {tx_upstream_debug_status, rx_downstream_debug_status},
            {exp_status, exp_status});
    drive_random();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) run_cycle();
  endtask

  initial begin
    int unsigned seed;
    int          ep;
    rst_n         = 1'b0;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    m_gen2_mode   = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    delay_z_value = '0;
    tx_hi         = 0;
    rx_hi         = 0;
    tx_flag       = 1'b0;
    rx_flag       = 1'b0;
    stb_phase     = 0;
    errors        = 0;
    checks        = 0;
    seed = $urandom(9583);
    drive_random();

    repeat (3) @(posedge clk_wr);
    #1;
    rst_n = 1'b1;
    compare("tx_phy0 after reset", tx_phy0, '0);
    compare("tx_phy1 after reset", tx_phy1, '0);
    compare("debug after reset", tx_upstream_debug_status, '0);

    //////////////////////////////////////////////////
    // Episodes of offline, online and drop phases
    for (ep = 0; ep < n_episodes; ep++) begin
      delay_x_value = 16'($urandom_range(0, 20));
      delay_y_value = 16'($urandom_range(0, 20));
      // Periods 0 and 1 first and wider ones after
      if (ep < 2) begin
        delay_z_value = 16'(ep);
      end else begin
        delay_z_value = 16'($urandom_range(2, 7));
      end
      m_gen2_mode = (ep % 2 == 0);
      run_cycles(off_cycles);
      tx_online = 1'b1;
      rx_online = 1'b1;
      run_cycles(on_cycles);
      tx_online = 1'b0;
      rx_online = 1'b0;
      run_cycles(drop_cycles);
    end

    errors = errors + UUT.u_assertions.fail_count;
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- tests/lpif_slave_assertions.sv
//////////////////////////////////////////////////
// Link slave assertions
// TX lane gating, marker value and strobe period
//////////////////////////////////////////////////

`timescale 1ns/1ns

module lpif_slave_assertions (
  input logic                                 clk_wr,
  input logic                                 rst_n,
  input logic                                 tx_on,
  input logic                                 m_gen2_mode,
  input logic [lpif_phy_pkg::delay_width-1:0] delay_z_value,
  input logic [lpif_phy_pkg::lane_width-1:0]  tx_phy0,
  input logic [lpif_phy_pkg::lane_width-1:0]  tx_phy1
);

  int   fail_count = 0;
  logic lanes_on;
  logic stb_seen;
  int   period;
  int   gap;

  // Strobe slot follows the PHY generation
  assign stb_seen = m_gen2_mode ? tx_phy0[lpif_phy_pkg::strobe_bit_gen2]
                                : tx_phy0[lpif_phy_pkg::strobe_bit_gen1];
  assign period   = (delay_z_value == '0) ? 1 : int'(delay_z_value);

  // Lanes carry data one cycle behind the flag
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      lanes_on <= 1'b0;
    end else begin
      lanes_on <= tx_on;
    end
  end

  // Cycles since the last strobe, zero before the first one
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !lanes_on) begin
      gap <= 0;
    end else if (stb_seen) begin
      gap <= 1;
    end else if (gap != 0) begin
      gap <= gap + 1;
    end
  end

  //////////////////////////////////////////////////
  // Properties
  lanes_silent: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_on |=> (tx_phy0 == '0 && tx_phy1 == '0))
    else begin
      $error("TX lanes not zero one cycle after offline");
      fail_count++;
    end

  marker_held: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_on |=> (tx_phy0[lpif_phy_pkg::marker_bit] == lpif_phy_pkg::auto_marker[0] &&
               tx_phy1[lpif_phy_pkg::marker_bit] == lpif_phy_pkg::auto_marker[1]))
    else begin
      $error("Lane marker bits differ from auto marker");
      fail_count++;
    end

  // First online lane cycle carries a strobe
  strobe_first: assert property (@(posedge clk_wr) disable iff (!rst_n)
    $rose(lanes_on) |-> stb_seen)
    else begin
      $error("No strobe in first online cycle");
      fail_count++;
    end

  strobe_period: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (lanes_on && gap != 0) |-> (stb_seen == (gap == period)))
    else begin
      $error("Strobe spacing differs from programmed period");
      fail_count++;
    end

endmodule

bind lpif_slave_top lpif_slave_assertions u_assertions (
  .clk_wr        (clk_wr),
  .rst_n         (rst_n),
  .tx_on         (tx_upstream_debug_status[19]),
  .m_gen2_mode   (m_gen2_mode),
  .delay_z_value (delay_z_value),
  .tx_phy0       (tx_phy0),
  .tx_phy1       (tx_phy1)
);

//--- src/lpif_slave_top.sv
//////////////////////////////////////////////////
// LPIF slave link top
// Single-channel, two-lane die-to-die link
// Auto-sync, user packing, PHY mapping, debug status
//////////////////////////////////////////////////

`timescale 1ns/1ns

module lpif_slave_top (
  input  logic                                      clk_wr,
  input  logic                                      rst_n,

  // Link control
  input  logic                                      tx_online,
  input  logic                                      rx_online,

  // PHY lanes
  output logic [lpif_phy_pkg::lane_width-1:0]       tx_phy0,
  input  logic [lpif_phy_pkg::lane_width-1:0]       rx_phy0,
  output logic [lpif_phy_pkg::lane_width-1:0]       tx_phy1,
  input  logic [lpif_phy_pkg::lane_width-1:0]       rx_phy1,

  // Downstream user bus
  output logic [lpif_link_pkg::state_width-1:0]     dstrm_state,
  output logic [lpif_link_pkg::protid_width-1:0]    dstrm_protid,
  output logic [lpif_link_pkg::data_width-1:0]      dstrm_data,
  output logic [lpif_link_pkg::dvalid_width-1:0]    dstrm_dvalid,
  output logic [lpif_link_pkg::crc_width-1:0]       dstrm_crc,
  output logic [lpif_link_pkg::crc_valid_width-1:0] dstrm_crc_valid,
  output logic [lpif_link_pkg::valid_width-1:0]     dstrm_valid,

  // Upstream user bus, sampled every cycle
  input  logic [lpif_link_pkg::state_width-1:0]     ustrm_state,
  input  logic [lpif_link_pkg::protid_width-1:0]    ustrm_protid,
  input  logic [lpif_link_pkg::data_width-1:0]      ustrm_data,
  input  logic [lpif_link_pkg::dvalid_width-1:0]    ustrm_dvalid,
  input  logic [lpif_link_pkg::crc_width-1:0]       ustrm_crc,
  input  logic [lpif_link_pkg::crc_valid_width-1:0] ustrm_crc_valid,
  input  logic [lpif_link_pkg::valid_width-1:0]     ustrm_valid,

  // Debug status
  output logic [31:0]                               rx_downstream_debug_status,
  output logic [31:0]                               tx_upstream_debug_status,

  // Configuration
  input  logic                                      m_gen2_mode,
  input  logic [lpif_phy_pkg::marker_width-1:0]     tx_mrk_userbit,
  input  logic                                      tx_stb_userbit,
  input  logic [lpif_phy_pkg::delay_width-1:0]      delay_x_value,
  input  logic [lpif_phy_pkg::delay_width-1:0]      delay_y_value,
  input  logic [lpif_phy_pkg::delay_width-1:0]      delay_z_value
);

  lpif_sync_if sync_bus ();

  logic [lpif_link_pkg::flit_width-1:0] tx_flit;
  logic [lpif_link_pkg::flit_width-1:0] rx_flit;
  logic [31:0]                          status_word;

  //////////////////////////////////////////////////
  // Auto-sync
  ll_auto_sync u_auto_sync (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .sync           (sync_bus.source)
  );

  //////////////////////////////////////////////////
  // User field packing, no FIFO in between
  lpif_user_pack u_user_pack (
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit)
  );

  //////////////////////////////////////////////////
  // PHY lane mapping
  lpif_phy_concat u_phy_concat (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .m_gen2_mode (m_gen2_mode),
    .sync        (sync_bus.sink),
    .tx_flit     (tx_flit),
    .rx_flit     (rx_flit),
    .tx_phy0     (tx_phy0),
    .tx_phy1     (tx_phy1),
    .rx_phy0     (rx_phy0),
    .rx_phy1     (rx_phy1)
  );

  // Debug word, delayed flags at bits 19 and 18
  always_comb begin
    status_word     = '0;
    status_word[19] = sync_bus.tx_online_delay;
    status_word[18] = sync_bus.rx_online_delay;
  end

  // Same word reported in both directions
  assign rx_downstream_debug_status = status_word;
  assign tx_upstream_debug_status   = status_word;

endmodule

//--- src/lpif_phy_concat.sv
//////////////////////////////////////////////////
// PHY lane mapper
// Registered flit to two-lane split on TX
// Registered two-lane to flit merge on RX
// Both directions gated by delayed online flags
//////////////////////////////////////////////////

`timescale 1ns/1ns

module lpif_phy_concat (
  input  logic                                  clk_wr,
  input  logic                                  rst_n,
  input  logic                                  m_gen2_mode,
  lpif_sync_if.sink                             sync,
  input  logic [lpif_link_pkg::flit_width-1:0]  tx_flit,
  output logic [lpif_link_pkg::flit_width-1:0]  rx_flit,
  output logic [lpif_phy_pkg::lane_width-1:0]   tx_phy0,
  output logic [lpif_phy_pkg::lane_width-1:0]   tx_phy1,
  input  logic [lpif_phy_pkg::lane_width-1:0]   rx_phy0,
  input  logic [lpif_phy_pkg::lane_width-1:0]   rx_phy1
);

  logic [lpif_phy_pkg::lane_width-1:0]  lane0_next;
  logic [lpif_phy_pkg::lane_width-1:0]  lane1_next;
  logic [lpif_link_pkg::flit_width-1:0] rx_merge;

  // Build one TX lane from its half flit and sync bits
  function automatic logic [lpif_phy_pkg::lane_width-1:0] build_lane(
    input logic [lpif_phy_pkg::half_width-1:0] half,
    input logic                                mrk,
    input logic                                stb,
    input logic                                gen2
  );
    logic [lpif_phy_pkg::lane_width-1:0] lane;
    lane = '0;
    lane[lpif_phy_pkg::half_width-1:0] = half;
    lane[lpif_phy_pkg::marker_bit]     = mrk;
    // Strobe slot depends on PHY generation
    if (gen2) begin
      lane[lpif_phy_pkg::strobe_bit_gen2] = stb;
    end else begin
      lane[lpif_phy_pkg::strobe_bit_gen1] = stb;
    end
    return lane;
  endfunction

  //////////////////////////////////////////////////
  // TX path
  // Low half on lane 0, high half on lane 1
  assign lane0_next = build_lane(tx_flit[lpif_phy_pkg::half_width-1:0],
                                 sync.mrk_userbit[0], sync.stb_userbit, m_gen2_mode);
  assign lane1_next = build_lane(
    tx_flit[lpif_link_pkg::flit_width-1:lpif_phy_pkg::half_width],
    sync.mrk_userbit[1], sync.stb_userbit, m_gen2_mode);

  // Silent lanes while TX is offline
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !sync.tx_online_delay) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= lane0_next;
      tx_phy1 <= lane1_next;
    end
  end

  //////////////////////////////////////////////////
  // RX path
  // Lane bits above the half flit carry sync only
  assign rx_merge = {rx_phy1[lpif_phy_pkg::half_width-1:0],
                     rx_phy0[lpif_phy_pkg::half_width-1:0]};

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !sync.rx_online_delay) begin
      rx_flit <= '0;
    end else begin
      rx_flit <= rx_merge;
    end
  end

endmodule

//--- src/lpif_user_pack.sv
//////////////////////////////////////////////////
// User bus packing
// Upstream fields into TX flit
// RX flit into downstream fields
//////////////////////////////////////////////////

`timescale 1ns/1ns

module lpif_user_pack (
  // Upstream user fields
  input  logic [lpif_link_pkg::state_width-1:0]     ustrm_state,
  input  logic [lpif_link_pkg::protid_width-1:0]    ustrm_protid,
  input  logic [lpif_link_pkg::data_width-1:0]      ustrm_data,
  input  logic [lpif_link_pkg::dvalid_width-1:0]    ustrm_dvalid,
  input  logic [lpif_link_pkg::crc_width-1:0]       ustrm_crc,
  input  logic [lpif_link_pkg::crc_valid_width-1:0] ustrm_crc_valid,
  input  logic [lpif_link_pkg::valid_width-1:0]     ustrm_valid,

  // Downstream user fields
  output logic [lpif_link_pkg::state_width-1:0]     dstrm_state,
  output logic [lpif_link_pkg::protid_width-1:0]    dstrm_protid,
  output logic [lpif_link_pkg::data_width-1:0]      dstrm_data,
  output logic [lpif_link_pkg::dvalid_width-1:0]    dstrm_dvalid,
  output logic [lpif_link_pkg::crc_width-1:0]       dstrm_crc,
  output logic [lpif_link_pkg::crc_valid_width-1:0] dstrm_crc_valid,
  output logic [lpif_link_pkg::valid_width-1:0]     dstrm_valid,

  // Flits to and from the PHY mapper
  output logic [lpif_link_pkg::flit_width-1:0]      tx_flit,
  input  logic [lpif_link_pkg::flit_width-1:0]      rx_flit
);

  //////////////////////////////////////////////////
  // TX packing
  // Every flit bit is covered by exactly one field
  always_comb begin
    tx_flit = '0;
    tx_flit[lpif_link_pkg::data_lsb      +: lpif_link_pkg::data_width]      = ustrm_data;
    tx_flit[lpif_link_pkg::state_lsb     +: lpif_link_pkg::state_width]     = ustrm_state;
    tx_flit[lpif_link_pkg::protid_lsb    +: lpif_link_pkg::protid_width]    = ustrm_protid;
    tx_flit[lpif_link_pkg::dvalid_lsb    +: lpif_link_pkg::dvalid_width]    = ustrm_dvalid;
    // CRC bits are plain user data here
    tx_flit[lpif_link_pkg::crc_lsb       +: lpif_link_pkg::crc_width]       = ustrm_crc;
    tx_flit[lpif_link_pkg::crc_valid_lsb +: lpif_link_pkg::crc_valid_width] = ustrm_crc_valid;
    tx_flit[lpif_link_pkg::valid_lsb     +: lpif_link_pkg::valid_width]     = ustrm_valid;
  end

  //////////////////////////////////////////////////
  // RX unpacking
  // Gating already applied in the PHY mapper register
  assign dstrm_data      = rx_flit[lpif_link_pkg::data_lsb +: lpif_link_pkg::data_width];
  assign dstrm_state     = rx_flit[lpif_link_pkg::state_lsb +: lpif_link_pkg::state_width];
  assign dstrm_protid    = rx_flit[lpif_link_pkg::protid_lsb +: lpif_link_pkg::protid_width];
  assign dstrm_dvalid    = rx_flit[lpif_link_pkg::dvalid_lsb +: lpif_link_pkg::dvalid_width];
  assign dstrm_crc       = rx_flit[lpif_link_pkg::crc_lsb +: lpif_link_pkg::crc_width];
  assign dstrm_crc_valid =
    rx_flit[lpif_link_pkg::crc_valid_lsb +: lpif_link_pkg::crc_valid_width];
  assign dstrm_valid     = rx_flit[lpif_link_pkg::valid_lsb +: lpif_link_pkg::valid_width];

endmodule

//--- src/ll_auto_sync.sv
//////////////////////////////////////////////////
// Logic link auto-sync
// Delays TX/RX online by programmable counts
// Persistent marker and periodic strobe when online
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ll_auto_sync (
  input  logic                                  clk_wr,
  input  logic                                  rst_n,
  input  logic                                  tx_online,
  input  logic                                  rx_online,
  input  logic [lpif_phy_pkg::delay_width-1:0]  delay_x_value,
  input  logic [lpif_phy_pkg::delay_width-1:0]  delay_y_value,
  input  logic [lpif_phy_pkg::delay_width-1:0]  delay_z_value,
  input  logic [lpif_phy_pkg::marker_width-1:0] tx_mrk_userbit,
  input  logic                                  tx_stb_userbit,
  lpif_sync_if.source                           sync
);

  // Path 0 is TX, path 1 is RX
  logic [1:0]                             path_req;
  logic [lpif_phy_pkg::delay_width-1:0]   path_delay [2];
  lpif_link_pkg::sync_state_e             path_state [2];
  logic [lpif_phy_pkg::delay_width-1:0]   path_cnt   [2];

  // Strobe period tracking
  logic [lpif_phy_pkg::delay_width-1:0]   stb_cnt;
  logic [lpif_phy_pkg::delay_width-1:0]   stb_last;
  logic                                   tx_on;
  logic                                   stb_pulse;

  assign path_req      = {rx_online, tx_online};
  assign path_delay[0] = delay_x_value;
  assign path_delay[1] = delay_y_value;

  //////////////////////////////////////////////////
  // Online delay machines
  // Sampled low input drops the path back to idle
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      if (!rst_n || !path_req[i]) begin
        path_state[i] <= lpif_link_pkg::sync_idle;
        path_cnt[i]   <= '0;
      end else begin
        case (path_state[i])
          lpif_link_pkg::sync_idle: begin
            // Load delay on first sampled high
            path_state[i] <= lpif_link_pkg::sync_wait;
            path_cnt[i]   <= path_delay[i];
          end
          lpif_link_pkg::sync_wait: begin
            if (path_cnt[i] == '0) begin
              path_state[i] <= lpif_link_pkg::sync_online;
            end else begin
              path_cnt[i] <= path_cnt[i] - 1'b1;
            end
          end
          default: begin
            // Hold online until input drops
            path_state[i] <= lpif_link_pkg::sync_online;
          end
        endcase
      end
    end
  end

  assign tx_on = (path_state[0] == lpif_link_pkg::sync_online);

  //////////////////////////////////////////////////
  // Strobe period counter
  // Zero period treated as one
  assign stb_last = (delay_z_value == '0) ? '0 : delay_z_value - 1'b1;

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_on) begin
      stb_cnt <= '0;
    end else if (stb_cnt >= stb_last) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 1'b1;
    end
  end

  // Count starts at zero so first online cycle pulses
  assign stb_pulse = (stb_cnt == '0);

  // Bundle outputs
  assign sync.tx_online_delay = tx_on;
  assign sync.rx_online_delay = (path_state[1] == lpif_link_pkg::sync_online);
  assign sync.mrk_userbit     = tx_on ? lpif_phy_pkg::auto_marker : tx_mrk_userbit;
  assign sync.stb_userbit     = tx_on ? stb_pulse : tx_stb_userbit;

endmodule

//--- src/lpif_sync_if.sv
//////////////////////////////////////////////////
// Sync bundle
// Delayed online flags, marker and strobe
//////////////////////////////////////////////////

`timescale 1ns/1ns

interface lpif_sync_if;

  logic                                  tx_online_delay;
  logic                                  rx_online_delay;
  logic [lpif_phy_pkg::marker_width-1:0] mrk_userbit;
  logic                                  stb_userbit;

  // Driven by the auto-sync block
  modport source (
    output tx_online_delay,
    output rx_online_delay,
    output mrk_userbit,
    output stb_userbit
  );

  // Consumed by the PHY mapper
  modport sink (
    input tx_online_delay,
    input rx_online_delay,
    input mrk_userbit,
    input stb_userbit
  );

  // Flags only, for debug status
  modport monitor (
    input tx_online_delay,
    input rx_online_delay
  );

endinterface

//--- src/lpif_phy_pkg.sv
//////////////////////////////////////////////////
// PHY lane definitions
// Lane width, half-flit split, sync bit positions
//////////////////////////////////////////////////

package lpif_phy_pkg;

  // Bits per PHY lane
  localparam int lane_width = 80;

  // Flit bits carried per lane, always in lane bits 41..0
  localparam int half_width = 42;

  //////////////////////////////////////////////////
  // Sync bit positions within a lane
  // Lane i carries marker bit i
  localparam int marker_bit = 79;

  // Strobe position in gen2 mode
  localparam int strobe_bit_gen2 = 78;
  // Strobe position in gen1 mode, just above the data
  localparam int strobe_bit_gen1 = 42;

  // One marker bit per lane
  localparam int marker_width = 2;

  // Online delay and strobe period counters
  localparam int delay_width = 16;

  // Marker held while TX is online
  localparam logic [marker_width-1:0] auto_marker = 2'b10;

endpackage

//--- src/lpif_link_pkg.sv
//////////////////////////////////////////////////
// Logic link definitions
// Flit layout, user field widths and offsets
// State encoding of the online delay paths
//////////////////////////////////////////////////

package lpif_link_pkg;

  // Packed flit carried across both lanes
  localparam int flit_width = 84;

  // User field widths
  localparam int data_width      = 64;
  localparam int state_width     = 8;
  localparam int protid_width    = 4;
  localparam int dvalid_width    = 2;
  localparam int crc_width       = 2;
  localparam int crc_valid_width = 2;
  localparam int valid_width     = 2;

  //////////////////////////////////////////////////
  // Field offsets, LSB first
  localparam int data_lsb      = 0;
  localparam int state_lsb     = data_lsb + data_width;
  localparam int protid_lsb    = state_lsb + state_width;
  localparam int dvalid_lsb    = protid_lsb + protid_width;
  localparam int crc_lsb       = dvalid_lsb + dvalid_width;
  localparam int crc_valid_lsb = crc_lsb + crc_width;
  // Top field ends exactly at flit bit 83
  localparam int valid_lsb     = crc_valid_lsb + crc_valid_width;

  // One machine per online delay path
  typedef enum logic [1:0] {
    sync_idle,
    sync_wait,
    sync_online
  } sync_state_e;

endpackage
